// File: sim.f
hw/alu_rs_pkg.sv
hw/rs_alloc.sv
hw/rs_entry.sv
hw/alu_issue.sv
hw/alu_rs_top.sv
sim/alu_rs_props.sv
sim/alu_rs_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := alu_rs_tb
FILELIST  := sim.f
FLAGS     := --timing --assert --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Simulation passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/alu_rs_tb.sv
`timescale 1ns/1ps

module alu_rs_tb import alu_rs_pkg::*; ();

localparam int RS_SIZE = 4;
localparam int TIMEOUT = 200;
localparam int NTAGS   = 2 ** TAG_W;

logic             clk = 1'b0;
logic             reset;
logic             flush;
logic             disp_valid;
logic             disp_ready;
alu_op_t          disp_op;
logic [TAG_W-1:0] disp_tag;
logic             disp_src1_ready;
logic [TAG_W-1:0] disp_src1_tag;
logic [XLEN-1:0]  disp_src1_value;
logic             disp_src2_ready;
logic [TAG_W-1:0] disp_src2_tag;
logic [XLEN-1:0]  disp_src2_value;
logic             wb_valid;
logic [TAG_W-1:0] wb_tag;
logic [XLEN-1:0]  wb_data;
logic             res_valid;
logic             res_ready = 1'b0;
logic [TAG_W-1:0] res_tag;
logic [XLEN-1:0]  res_data;

integer          seed = 32'ha6de_5894;
// res_ready pattern: 0 random, 1 held low, 2 held high
int              ready_mode;
logic [255:0]    ready_bits;
logic [7:0]      ready_idx = '0;
// per tag: dispatched, consumed, flushed
int              issued [NTAGS];
int              taken [NTAGS];
int              killed [NTAGS];
logic [XLEN-1:0] expected [NTAGS];
int              checks;
int              mismatches;
int              errors;
int              test_num;

alu_rs_top #(.RS_SIZE(RS_SIZE)) dut_i (.*);

always #5 clk = ~clk;

always @(negedge clk) begin
	case (ready_mode)
		0: res_ready = ready_bits[ready_idx];
		1: res_ready = 1'b0;
		default: res_ready = 1'b1;
	endcase
	ready_idx = ready_idx + 8'd1;
end

always @(posedge clk) begin
	if (!reset && res_valid && res_ready) begin
		taken[res_tag] <= taken[res_tag] + 1;
		checks <= checks + 1;
	end
end

tag_expected: assert property (@(posedge clk) disable iff (reset)
	res_valid && res_ready |-> issued[res_tag] > taken[res_tag] + killed[res_tag])
else begin
	mismatches++;
	$display("result for tag %0d was not expected or came twice, at %0t",
		$sampled(res_tag), $time);
end

data_match: assert property (@(posedge clk) disable iff (reset)
	res_valid && res_ready |-> res_data == expected[res_tag])
else begin
	mismatches++;
	$display("** Error at %0t: tag %0d gave %h, expected %h", $time,
		$sampled(res_tag), $sampled(res_data), expected[$sampled(res_tag)]);
end

function automatic logic [XLEN-1:0] next_random();
	return $random(seed);
endfunction

function automatic logic producer_done(input logic [TAG_W-1:0] t);
	return issued[t] != 0 && taken[t] + killed[t] >= issued[t];
endfunction

function automatic int outstanding();
	int sum;
	sum = 0;
	for (int t = 0; t < NTAGS; t++)
		sum += issued[t] - taken[t] - killed[t];
	return sum;
endfunction

task automatic note_error(input string msg);
	errors++;
	$display("** Error at %0t: %s", $time, msg);
endtask

task automatic timeout(input string what);
	$display("timed out waiting for %s", what);
	$display("Simulation failed");
	$finish;
endtask

// a waiting source turns ready once its producer has been consumed
task automatic dispatch(input alu_op_t op, input logic [TAG_W-1:0] tag,
		input logic w1, input logic [TAG_W-1:0] t1, input logic [XLEN-1:0] v1,
		input logic w2, input logic [TAG_W-1:0] t2, input logic [XLEN-1:0] v2);
	int   cycles;
	logic accepted;
	cycles = 0;
	accepted = 1'b0;
	while (!accepted) begin
		@(negedge clk);
		if (cycles == 0) begin
			expected[tag] = alu_eval(op, v1, v2);
			issued[tag]++;
		end
		disp_valid = 1'b1;
		disp_op = op;
		disp_tag = tag;
		disp_src1_ready = !w1 || producer_done(t1);
		disp_src1_tag = t1;
		disp_src1_value = v1;
		disp_src2_ready = !w2 || producer_done(t2);
		disp_src2_tag = t2;
		disp_src2_value = v2;
		@(posedge clk);
		accepted = disp_ready;
		cycles++;
		if (!accepted && cycles >= TIMEOUT)
			timeout("dispatch handshake");
	end
endtask

task automatic dispatch_ready(input alu_op_t op, input logic [TAG_W-1:0] tag,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
	dispatch(op, tag, 1'b0, '0, a, 1'b0, '0, b);
endtask

task automatic check_and_dispatch(input alu_op_t op, input logic [TAG_W-1:0] tag,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] want);
	assert (alu_eval(op, a, b) == want)
	else note_error($sformatf("%s of %h and %h gave %h, expected %h",
		op.name(), a, b, alu_eval(op, a, b), want));
	dispatch_ready(op, tag, a, b);
endtask

task automatic idle(input int n);
	repeat (n) begin
		@(negedge clk);
		disp_valid = 1'b0;
	end
endtask

task automatic drive_wb(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] data);
	@(negedge clk);
	disp_valid = 1'b0;
	wb_valid = 1'b1;
	wb_tag = tag;
	wb_data = data;
	@(negedge clk);
	wb_valid = 1'b0;
endtask

task automatic drain(input string what);
	int cycles;
	cycles = 0;
	@(negedge clk);
	disp_valid = 1'b0;
	while (outstanding() != 0) begin
		cycles++;
		if (cycles >= TIMEOUT)
			timeout(what);
		@(negedge clk);
	end
endtask

task automatic report(input string name);
	test_num++;
	$display("test %0d %s finished: %0d results checked, %0d errors so far",
		test_num, name, checks, errors + mismatches);
endtask

initial begin : main
	logic [XLEN-1:0] x;
	logic [XLEN-1:0] y;
	logic [XLEN-1:0] z;
	int              total;
	reset = 1'b1;
	flush = 1'b0;
	disp_valid = 1'b0;
	disp_op = OP_ADD;
	disp_tag = '0;
	disp_src1_ready = 1'b0;
	disp_src1_tag = '0;
	disp_src1_value = '0;
	disp_src2_ready = 1'b0;
	disp_src2_tag = '0;
	disp_src2_value = '0;
	wb_valid = 1'b0;
	wb_tag = '0;
	wb_data = '0;
	ready_mode = 2;
	for (int i = 0; i < 8; i++)
		ready_bits[i*32 +: 32] = next_random();
	repeat (4) @(posedge clk);
	@(negedge clk);
	reset = 1'b0;

	ready_mode = 0;
	check_and_dispatch(OP_ADD, 0, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
	check_and_dispatch(OP_SUB, 1, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff);
	check_and_dispatch(OP_AND, 2, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
	check_and_dispatch(OP_OR, 3, 32'hf0f0_f0f0, 32'h0f0f_0000, 32'hffff_f0f0);
	check_and_dispatch(OP_XOR, 4, 32'haaaa_5555, 32'hffff_0000, 32'h5555_5555);
	check_and_dispatch(OP_SLL, 5, 32'h0000_0001, 32'h0000_0021, 32'h0000_0002);
	check_and_dispatch(OP_SRL, 6, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
	check_and_dispatch(OP_SRA, 7, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
	check_and_dispatch(OP_SLT, 8, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
	check_and_dispatch(OP_SLTU, 9, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
	drain("opcode results");
	report("opcodes");

	ready_mode = 2;
	x = next_random();
	y = next_random();
	z = next_random();
	dispatch_ready(OP_ADD, 10, x, y);
	dispatch(OP_SUB, 11, 1'b1, 10, expected[10], 1'b0, '0, z);
	dispatch(OP_XOR, 12, 1'b0, '0, x, 1'b1, 11, expected[11]);
	drain("dependency chain");
	// consumer accepted in the producer's handshake cycle
	dispatch_ready(OP_OR, 13, x, z);
	idle(1);
	dispatch(OP_SRL, 14, 1'b1, 13, expected[13], 1'b0, '0, y);
	dispatch(OP_ADD, 15, 1'b1, 14, expected[14], 1'b1, 14, expected[14]);
	drain("bypass chain");
	report("dependency wakeup");

	ready_mode = 0;
	x = next_random();
	y = next_random();
	z = next_random();
	dispatch(OP_AND, 16, 1'b1, 24, x, 1'b0, '0, z);
	dispatch(OP_SRA, 17, 1'b1, 25, y, 1'b1, 24, x);
	dispatch(OP_SLTU, 18, 1'b0, '0, z, 1'b1, 25, y);
	idle(2);
	drive_wb(24, x);
	idle(1);
	drive_wb(25, y);
	drain("writeback consumers");
	report("external writeback");

	ready_mode = 1;
	for (int i = 0; i <= RS_SIZE; i++)
		dispatch_ready(OP_ADD, TAG_W'(i), next_random(), next_random());
	idle(1);
	@(posedge clk);
	assert (!disp_ready)
	else note_error("dispatch still ready with every entry and the output slot full");
	idle(3);
	ready_mode = 0;
	drain("back-pressure release");
	report("full station");

	ready_mode = 1;
	for (int i = 5; i < 8; i++)
		dispatch_ready(OP_XOR, TAG_W'(i), next_random(), next_random());
	dispatch(OP_ADD, 8, 1'b1, 7, expected[7], 1'b0, '0, next_random());
	@(negedge clk);
	disp_valid = 1'b0;
	flush = 1'b1;
	for (int i = 5; i <= 8; i++)
		killed[i]++;
	@(negedge clk);
	flush = 1'b0;
	ready_mode = 0;
	idle(2);
	x = next_random();
	y = next_random();
	z = next_random();
	dispatch_ready(OP_SUB, 5, x, y);
	dispatch(OP_SLL, 9, 1'b1, 5, expected[5], 1'b0, '0, z);
	drain("dispatch after flush");
	idle(4);
	report("flush");

	total = errors + mismatches + dut_i.props_i.failures;
	$display("tests %0d, results checked %0d, errors %0d", test_num, checks, total);
	if (total == 0)
		$display("Simulation passed");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

// File: sim/alu_rs_props.sv
`timescale 1ns/1ps

module alu_rs_props import alu_rs_pkg::*; #(
	parameter int RS_SIZE = 4
) (
	input logic               clk,
	input logic               reset,
	input logic               flush,
	input logic               disp_ready,
	input logic [RS_SIZE-1:0] ent_busy,
	input logic               res_valid,
	input logic               res_ready,
	input logic [TAG_W-1:0]   res_tag,
	input logic [XLEN-1:0]    res_data
);

int failures;

// idle and accepting right after reset
reset_clears: assert property (@(posedge clk) reset |=> !res_valid && disp_ready)
else begin
	failures++;
	$error("result valid or dispatch blocked after reset");
end

// held result must not move under back-pressure
stall_stable: assert property (@(posedge clk) disable iff (reset || flush)
	res_valid && !res_ready |=> res_valid && $stable(res_tag) && $stable(res_data))
else begin
	failures++;
	$error("result slot changed while stalled");
end

full_blocks: assert property (@(posedge clk) disable iff (reset)
	&ent_busy |-> !disp_ready)
else begin
	failures++;
	$error("dispatch ready with all entries busy");
end

flush_clears: assert property (@(posedge clk) disable iff (reset)
	flush |=> !res_valid)
else begin
	failures++;
	$error("result still valid after flush");
end

endmodule

bind alu_rs_top alu_rs_props #(.RS_SIZE(RS_SIZE)) props_i (
	.clk        ( clk        ),
	.reset      ( reset      ),
	.flush      ( flush      ),
	.disp_ready ( disp_ready ),
	.ent_busy   ( ent_busy   ),
	.res_valid  ( res_valid  ),
	.res_ready  ( res_ready  ),
	.res_tag    ( res_tag    ),
	.res_data   ( res_data   )
);

// File: hw/alu_rs_top.sv
`timescale 1ns/1ps

module alu_rs_top import alu_rs_pkg::*; #(
	parameter int RS_SIZE = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,

	input  logic             disp_valid,
	output logic             disp_ready,
	input  alu_op_t          disp_op,
	input  logic [TAG_W-1:0] disp_tag,
	input  logic             disp_src1_ready,
	input  logic [TAG_W-1:0] disp_src1_tag,
	input  logic [XLEN-1:0]  disp_src1_value,
	input  logic             disp_src2_ready,
	input  logic [TAG_W-1:0] disp_src2_tag,
	input  logic [XLEN-1:0]  disp_src2_value,

	input  logic             wb_valid,
	input  logic [TAG_W-1:0] wb_tag,
	input  logic [XLEN-1:0]  wb_data,

	output logic             res_valid,
	input  logic             res_ready,
	output logic [TAG_W-1:0] res_tag,
	output logic [XLEN-1:0]  res_data
);

// own result bus, looped back to allocator and entries
logic             fire_valid;
logic [TAG_W-1:0] fire_tag;
logic [XLEN-1:0]  fire_data;

logic [RS_SIZE-1:0] load_en;
alu_op_t            load_op;
logic [TAG_W-1:0]   load_tag;
logic               load_src1_ready;
logic [TAG_W-1:0]   load_src1_tag;
logic [XLEN-1:0]    load_src1_value;
logic               load_src2_ready;
logic [TAG_W-1:0]   load_src2_tag;
logic [XLEN-1:0]    load_src2_value;

logic [RS_SIZE-1:0]            ent_busy;
logic [RS_SIZE-1:0]            ent_req;
logic [RS_SIZE-1:0]            ent_grant;
alu_op_t [RS_SIZE-1:0]         ent_op;
logic [RS_SIZE-1:0][TAG_W-1:0] ent_tag;
logic [RS_SIZE-1:0][XLEN-1:0]  ent_a;
logic [RS_SIZE-1:0][XLEN-1:0]  ent_b;

rs_alloc #(
	.RS_SIZE ( RS_SIZE )
) alloc_i (
	.disp_valid      ( disp_valid      ),
	.disp_op         ( disp_op         ),
	.disp_tag        ( disp_tag        ),
	.disp_src1_ready ( disp_src1_ready ),
	.disp_src1_tag   ( disp_src1_tag   ),
	.disp_src1_value ( disp_src1_value ),
	.disp_src2_ready ( disp_src2_ready ),
	.disp_src2_tag   ( disp_src2_tag   ),
	.disp_src2_value ( disp_src2_value ),
	.disp_ready      ( disp_ready      ),
	.entry_busy      ( ent_busy        ),
	.flush           ( flush           ),
	.wb_valid        ( wb_valid        ),
	.wb_tag          ( wb_tag          ),
	.wb_data         ( wb_data         ),
	.fire_valid      ( fire_valid      ),
	.fire_tag        ( fire_tag        ),
	.fire_data       ( fire_data       ),
	.load_en         ( load_en         ),
	.load_op         ( load_op         ),
	.load_tag        ( load_tag        ),
	.load_src1_ready ( load_src1_ready ),
	.load_src1_tag   ( load_src1_tag   ),
	.load_src1_value ( load_src1_value ),
	.load_src2_ready ( load_src2_ready ),
	.load_src2_tag   ( load_src2_tag   ),
	.load_src2_value ( load_src2_value )
);

for (genvar i = 0; i < RS_SIZE; i++) begin : gen_entry
	rs_entry entry_i (
		.clk             ( clk             ),
		.reset           ( reset           ),
		.flush           ( flush           ),
		.load_en         ( load_en[i]      ),
		.load_op         ( load_op         ),
		.load_tag        ( load_tag        ),
		.load_src1_ready ( load_src1_ready ),
		.load_src1_tag   ( load_src1_tag   ),
		.load_src1_value ( load_src1_value ),
		.load_src2_ready ( load_src2_ready ),
		.load_src2_tag   ( load_src2_tag   ),
		.load_src2_value ( load_src2_value ),
		.grant           ( ent_grant[i]    ),
		.wb_valid        ( wb_valid        ),
		.wb_tag          ( wb_tag          ),
		.wb_data         ( wb_data         ),
		.fire_valid      ( fire_valid      ),
		.fire_tag        ( fire_tag        ),
		.fire_data       ( fire_data       ),
		.busy            ( ent_busy[i]     ),
		.req             ( ent_req[i]      ),
		.op              ( ent_op[i]       ),
		.tag             ( ent_tag[i]      ),
		.a               ( ent_a[i]        ),
		.b               ( ent_b[i]        )
	);
end

alu_issue #(
	.RS_SIZE ( RS_SIZE )
) issue_i (
	.clk        ( clk        ),
	.reset      ( reset      ),
	.flush      ( flush      ),
	.req        ( ent_req    ),
	.op         ( ent_op     ),
	.tag        ( ent_tag    ),
	.a          ( ent_a      ),
	.b          ( ent_b      ),
	.grant      ( ent_grant  ),
	.res_valid  ( res_valid  ),
	.res_tag    ( res_tag    ),
	.res_data   ( res_data   ),
	.res_ready  ( res_ready  ),
	.fire_valid ( fire_valid ),
	.fire_tag   ( fire_tag   ),
	.fire_data  ( fire_data  )
);

endmodule

// File: hw/alu_issue.sv
`timescale 1ns/1ps

module alu_issue import alu_rs_pkg::*; #(
	parameter int RS_SIZE = 4
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          flush,

	input  logic [RS_SIZE-1:0]            req,
	input  alu_op_t [RS_SIZE-1:0]         op,
	input  logic [RS_SIZE-1:0][TAG_W-1:0] tag,
	input  logic [RS_SIZE-1:0][XLEN-1:0]  a,
	input  logic [RS_SIZE-1:0][XLEN-1:0]  b,
	output logic [RS_SIZE-1:0]            grant,

	output logic                          res_valid,
	output logic [TAG_W-1:0]              res_tag,
	output logic [XLEN-1:0]               res_data,
	input  logic                          res_ready,

	output logic                          fire_valid,
	output logic [TAG_W-1:0]              fire_tag,
	output logic [XLEN-1:0]               fire_data
);

localparam int IDX_W = $clog2(RS_SIZE);

logic             slot_open;
logic             issue;
logic [IDX_W-1:0] sel_idx;
logic [XLEN-1:0]  sel_result;

// slot takes a new result when empty or draining this cycle
assign slot_open = !res_valid || res_ready;
assign issue     = (|req) && slot_open && !flush;

// lowest requesting index
always_comb begin
	sel_idx = '0;
	for (int i = RS_SIZE - 1; i >= 0; i--) begin
		if (req[i])
			sel_idx = IDX_W'(i);
	end
end

always_comb begin
	grant = '0;
	if (issue)
		grant[sel_idx] = 1'b1;
end

assign sel_result = alu_eval(op[sel_idx], a[sel_idx], b[sel_idx]);

always_ff @(posedge clk) begin
	if (reset || flush)
		res_valid <= 1'b0;
	else if (issue)
		res_valid <= 1'b1;
	else if (res_ready)
		res_valid <= 1'b0;
end

always_ff @(posedge clk) begin
	if (issue) begin
		res_tag  <= tag[sel_idx];
		res_data <= sel_result;
	end
end

// dependents wake when the consumer takes the value
assign fire_valid = res_valid && res_ready;
assign fire_tag   = res_tag;
assign fire_data  = res_data;

endmodule

// File: hw/rs_entry.sv
`timescale 1ns/1ps

module rs_entry import alu_rs_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             flush,

	input  logic             load_en,
	input  alu_op_t          load_op,
	input  logic [TAG_W-1:0] load_tag,
	input  logic             load_src1_ready,
	input  logic [TAG_W-1:0] load_src1_tag,
	input  logic [XLEN-1:0]  load_src1_value,
	input  logic             load_src2_ready,
	input  logic [TAG_W-1:0] load_src2_tag,
	input  logic [XLEN-1:0]  load_src2_value,

	input  logic             grant,

	input  logic             wb_valid,
	input  logic [TAG_W-1:0] wb_tag,
	input  logic [XLEN-1:0]  wb_data,
	input  logic             fire_valid,
	input  logic [TAG_W-1:0] fire_tag,
	input  logic [XLEN-1:0]  fire_data,

	output logic             busy,
	output logic             req,
	output alu_op_t          op,
	output logic [TAG_W-1:0] tag,
	output logic [XLEN-1:0]  a,
	output logic [XLEN-1:0]  b
);

typedef enum logic {
	ENT_FREE,
	ENT_WAIT
} ent_state_t;

ent_state_t       state;
logic             a_ready;
logic             b_ready;
logic [TAG_W-1:0] a_tag;
logic [TAG_W-1:0] b_tag;
logic [XLEN:0]    a_wake;
logic [XLEN:0]    b_wake;

function automatic logic [XLEN:0] snoop(input logic [TAG_W-1:0] want);
	if (fire_valid && fire_tag == want)
		return {1'b1, fire_data};
	if (wb_valid && wb_tag == want)
		return {1'b1, wb_data};
	return {1'b0, {XLEN{1'b0}}};
endfunction

always_comb begin
	a_wake = snoop(a_tag);
	b_wake = snoop(b_tag);
end

assign busy = (state == ENT_WAIT);
assign req  = busy && a_ready && b_ready;

always_ff @(posedge clk) begin
	if (reset || flush) begin
		state   <= ENT_FREE;
		a_ready <= 1'b0;
		b_ready <= 1'b0;
	end else if (load_en) begin
		state   <= ENT_WAIT;
		a_ready <= load_src1_ready;
		b_ready <= load_src2_ready;
	end else if (grant) begin
		state   <= ENT_FREE;
		a_ready <= 1'b0;
		b_ready <= 1'b0;
	end else if (state == ENT_WAIT) begin
		// wakeup on tag match
		if (!a_ready && a_wake[XLEN])
			a_ready <= 1'b1;
		if (!b_ready && b_wake[XLEN])
			b_ready <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (load_en) begin
		op    <= load_op;
		tag   <= load_tag;
		a_tag <= load_src1_tag;
		b_tag <= load_src2_tag;
		a     <= load_src1_value;
		b     <= load_src2_value;
	end else begin
		if (!a_ready && a_wake[XLEN])
			a <= a_wake[XLEN-1:0];
		if (!b_ready && b_wake[XLEN])
			b <= b_wake[XLEN-1:0];
	end
end

endmodule

// File: hw/rs_alloc.sv
`timescale 1ns/1ps

module rs_alloc import alu_rs_pkg::*; #(
	parameter int RS_SIZE = 4
) (
	input  logic               disp_valid,
	input  alu_op_t            disp_op,
	input  logic [TAG_W-1:0]   disp_tag,
	input  logic               disp_src1_ready,
	input  logic [TAG_W-1:0]   disp_src1_tag,
	input  logic [XLEN-1:0]    disp_src1_value,
	input  logic               disp_src2_ready,
	input  logic [TAG_W-1:0]   disp_src2_tag,
	input  logic [XLEN-1:0]    disp_src2_value,
	output logic               disp_ready,

	input  logic [RS_SIZE-1:0] entry_busy,
	input  logic               flush,

	input  logic               wb_valid,
	input  logic [TAG_W-1:0]   wb_tag,
	input  logic [XLEN-1:0]    wb_data,
	input  logic               fire_valid,
	input  logic [TAG_W-1:0]   fire_tag,
	input  logic [XLEN-1:0]    fire_data,

	output logic [RS_SIZE-1:0] load_en,
	output alu_op_t            load_op,
	output logic [TAG_W-1:0]   load_tag,
	output logic               load_src1_ready,
	output logic [TAG_W-1:0]   load_src1_tag,
	output logic [XLEN-1:0]    load_src1_value,
	output logic               load_src2_ready,
	output logic [TAG_W-1:0]   load_src2_tag,
	output logic [XLEN-1:0]    load_src2_value
);

localparam int IDX_W = $clog2(RS_SIZE);

logic             any_free;
logic [IDX_W-1:0] free_idx;
logic [XLEN:0]    src1_hit;
logic [XLEN:0]    src2_hit;

// {hit, data} for a tag seen on either result bus this cycle
function automatic logic [XLEN:0] snoop(input logic [TAG_W-1:0] want);
	if (fire_valid && fire_tag == want)
		return {1'b1, fire_data};
	if (wb_valid && wb_tag == want)
		return {1'b1, wb_data};
	return {1'b0, {XLEN{1'b0}}};
endfunction

// lowest free entry wins
always_comb begin
	any_free = 1'b0;
	free_idx = '0;
	for (int i = RS_SIZE - 1; i >= 0; i--) begin
		if (!entry_busy[i]) begin
			any_free = 1'b1;
			free_idx = IDX_W'(i);
		end
	end
end

assign disp_ready = any_free && !flush;

always_comb begin
	load_en = '0;
	if (disp_valid && disp_ready)
		load_en[free_idx] = 1'b1;
end

// bypass: a result broadcast in the dispatch cycle is caught here
always_comb begin
	src1_hit = snoop(disp_src1_tag);
	src2_hit = snoop(disp_src2_tag);
	load_op = disp_op;
	load_tag = disp_tag;
	load_src1_tag = disp_src1_tag;
	load_src2_tag = disp_src2_tag;
	load_src1_ready = disp_src1_ready || src1_hit[XLEN];
	load_src2_ready = disp_src2_ready || src2_hit[XLEN];
	load_src1_value = disp_src1_ready ? disp_src1_value : src1_hit[XLEN-1:0];
	load_src2_value = disp_src2_ready ? disp_src2_value : src2_hit[XLEN-1:0];
end

endmodule

// File: hw/alu_rs_pkg.sv
package alu_rs_pkg;

localparam int XLEN  = 32;
localparam int TAG_W = 5;

typedef enum logic [3:0] {
	OP_ADD  = 4'd0,
	OP_SUB  = 4'd1,
	OP_AND  = 4'd2,
	OP_OR   = 4'd3,
	OP_XOR  = 4'd4,
	OP_SLL  = 4'd5,
	OP_SRL  = 4'd6,
	OP_SRA  = 4'd7,
	OP_SLT  = 4'd8,
	OP_SLTU = 4'd9
} alu_op_t;

// integer ALU, shift amount from b[4:0]
function automatic logic [XLEN-1:0] alu_eval(
	input alu_op_t         op,
	input logic [XLEN-1:0] a,
	input logic [XLEN-1:0] b
);
	logic [4:0]      shamt;
	logic [XLEN-1:0] result;

	shamt = b[4:0];
	case (op)
		OP_ADD:  result = a + b;
		OP_SUB:  result = a - b;
		OP_AND:  result = a & b;
		OP_OR:   result = a | b;
		OP_XOR:  result = a ^ b;
		OP_SLL:  result = a << shamt;
		OP_SRL:  result = a >> shamt;
		OP_SRA:  result = $signed(a) >>> shamt;
		// compares give 0 or 1
		OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
		OP_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
		default: result = '0;
	endcase
	return result;
endfunction

endpackage
